//--- build.f
design/DaqPkg.sv
design/SlaveDaq.sv
design/ReadoutCapture.sv
design/DaqRegs.sv
design/DaqTop.sv
test/AsicModel.sv
test/DaqTb.sv

//--- design/DaqPkg.sv
`default_nettype none

package DaqPkg;

    localparam int RegWidth = 16;           // Wishbone data, timing registers, readout words

    // Sequencer delays in Clk cycles
    localparam int TimeMinPowerReset = 8;   // LVDS receiver wake up
    localparam int TimeMinResetStart = 40;  // Slow and fast clock ticks for internal management
    localparam int TimeMinSro = 16;         // Readout clock wake up

    typedef enum logic [3:0] {
        Idle,
        ChipReset,
        PowerOn,
        Release,
        WaitStart,
        Acquire,
        WaitRead,
        StartRead,
        WaitReadDone,
        OnceEndSt,
        AllDoneSt
    } DaqStateT;

    typedef enum logic [2:0] {
        AddrCtrl     = 3'd0,    // Bit 0 is ModuleStart
        AddrAcqTime  = 3'd1,
        AddrHoldTime = 3'd2,
        AddrStatus   = 3'd3,    // Overflow, AllDone, FIFO empty, state
        AddrCount    = 3'd4,    // Finished acquisitions
        AddrData     = 3'd5     // FIFO pop
    } RegAddrT;

endpackage

`default_nettype wire

//--- design/DaqRegs.sv
`timescale 1ns/1ps
`default_nettype none

module DaqRegs #(
    parameter int DefaultAcqTime = 8
) (
    input  logic                         Clk,
    input  logic                         reset_n,
    input  logic                         WbCyc,
    input  logic                         WbStb,
    input  logic                         WbWe,
    input  logic [2:0]                   WbAdr,
    input  logic [DaqPkg::RegWidth-1:0]  WbDatI,
    output logic [DaqPkg::RegWidth-1:0]  WbDatO,
    output logic                         WbAck,
    input  DaqPkg::DaqStateT             State,
    input  logic                         OnceEnd,
    input  logic                         AllDone,
    input  logic                         FifoEmpty,
    input  logic                         Overflow,
    input  logic [DaqPkg::RegWidth-1:0]  FifoData,
    output logic                         FifoPop,
    output logic                         ModuleStart,
    output logic [DaqPkg::RegWidth-1:0]  AcquisitionTime,
    output logic [DaqPkg::RegWidth-1:0]  EndHoldTime
);
    import DaqPkg::*;

    logic                Req;           // Cycle waiting for its ack
    logic                StartWrite;
    logic                OnceEndDly;
    logic                AllDoneSticky;
    logic [RegWidth-1:0] AcqCount;
    logic [RegWidth-1:0] ReadMux;
    RegAddrT             Addr;

    assign Addr       = RegAddrT'(WbAdr);
    assign Req        = WbCyc && WbStb && !WbAck;
    assign FifoPop    = Req && !WbWe && (Addr == AddrData) && !FifoEmpty;
    assign StartWrite = Req && WbWe && (Addr == AddrCtrl) && WbDatI[0];

    always_comb begin
        case (Addr)
            AddrCtrl:     ReadMux = {{(RegWidth-1){1'b0}}, ModuleStart};
            AddrAcqTime:  ReadMux = AcquisitionTime;
            AddrHoldTime: ReadMux = EndHoldTime;
            AddrStatus:   ReadMux = {{(RegWidth-7){1'b0}}, Overflow, AllDoneSticky,
                                     FifoEmpty, State};
            AddrCount:    ReadMux = AcqCount;
            AddrData:     ReadMux = FifoEmpty ? '0 : FifoData;   // Empty reads give zero
            default:      ReadMux = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Wishbone ack and register writes
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            WbAck           <= 1'b0;
            ModuleStart     <= 1'b0;
            AcquisitionTime <= RegWidth'(DefaultAcqTime);
            EndHoldTime     <= '0;
        end else begin
            WbAck <= Req;                   // Single cycle ack
            if (Req && WbWe) begin
                case (Addr)
                    AddrCtrl:     ModuleStart     <= WbDatI[0];
                    AddrAcqTime:  AcquisitionTime <= WbDatI;
                    AddrHoldTime: EndHoldTime     <= WbDatI;
                    default:      ;             // Read-only addresses
                endcase
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (Req) WbDatO <= ReadMux;         // Valid with the ack
    end

    // Acquisition counter and sticky AllDone
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            OnceEndDly    <= 1'b0;
            AcqCount      <= '0;
            AllDoneSticky <= 1'b0;
        end else begin
            OnceEndDly <= OnceEnd;
            if (OnceEnd && !OnceEndDly) AcqCount <= AcqCount + 1'b1;
            if (AllDone) begin
                AllDoneSticky <= 1'b1;
            end else if (StartWrite) begin
                AllDoneSticky <= 1'b0;      // New run clears it
            end
        end
    end

    assert property (@(posedge Clk) disable iff (!reset_n) WbAck |=> !WbAck);

endmodule

`default_nettype wire

//--- design/DaqTop.sv
`timescale 1ns/1ps
`default_nettype none

module DaqTop #(
    parameter int FifoDepth      = 16,
    parameter int DefaultAcqTime = 8
) (
    input  logic                         Clk,
    input  logic                         reset_n,
    input  logic                         WbCyc,
    input  logic                         WbStb,
    input  logic                         WbWe,
    input  logic [2:0]                   WbAdr,
    input  logic [DaqPkg::RegWidth-1:0]  WbDatI,
    output logic [DaqPkg::RegWidth-1:0]  WbDatO,
    output logic                         WbAck,
    input  logic                         AcqStart,
    input  logic                         ChipSatB,
    input  logic                         Dout,
    input  logic                         TransmitOnB,
    output logic                         ResetB,
    output logic                         StartAcq,
    output logic                         StartReadout,
    output logic                         PwrOnA,
    output logic                         PwrOnD,
    output logic                         PwrOnDac
);
    import DaqPkg::*;

    DaqStateT            State;
    logic                ModuleStart, OnceEnd, AllDone, EndReadout;
    logic                FifoPop, FifoEmpty, Overflow;
    logic [RegWidth-1:0] AcquisitionTime, EndHoldTime, FifoData;

    DaqRegs #(.DefaultAcqTime(DefaultAcqTime)) regs (
        .Clk(Clk), .reset_n(reset_n),
        .WbCyc(WbCyc), .WbStb(WbStb), .WbWe(WbWe), .WbAdr(WbAdr),
        .WbDatI(WbDatI), .WbDatO(WbDatO), .WbAck(WbAck),
        .State(State), .OnceEnd(OnceEnd), .AllDone(AllDone),
        .FifoEmpty(FifoEmpty), .Overflow(Overflow), .FifoData(FifoData),
        .FifoPop(FifoPop), .ModuleStart(ModuleStart),
        .AcquisitionTime(AcquisitionTime), .EndHoldTime(EndHoldTime)
    );

    SlaveDaq daq (
        .Clk(Clk), .reset_n(reset_n),
        .ModuleStart(ModuleStart), .AcqStart(AcqStart), .ChipSatB(ChipSatB),
        .EndReadout(EndReadout),
        .AcquisitionTime(AcquisitionTime), .EndHoldTime(EndHoldTime),
        .ResetB(ResetB), .StartAcq(StartAcq), .StartReadout(StartReadout),
        .PwrOnA(PwrOnA), .PwrOnD(PwrOnD), .PwrOnDac(PwrOnDac),
        .OnceEnd(OnceEnd), .AllDone(AllDone), .State(State)
    );

    // Readout request also goes out to the chain
    ReadoutCapture #(.FifoDepth(FifoDepth)) capture (
        .Clk(Clk), .reset_n(reset_n),
        .StartReadout(StartReadout), .Dout(Dout), .TransmitOnB(TransmitOnB),
        .FifoPop(FifoPop), .EndReadout(EndReadout), .FifoEmpty(FifoEmpty),
        .Overflow(Overflow), .FifoData(FifoData)
    );

endmodule

`default_nettype wire

//--- design/ReadoutCapture.sv
`timescale 1ns/1ps
`default_nettype none

module ReadoutCapture #(
    parameter int FifoDepth = 16
) (
    input  logic                         Clk,
    input  logic                         reset_n,
    input  logic                         StartReadout,
    input  logic                         Dout,          // Serial data, MSB first
    input  logic                         TransmitOnB,   // Data valid, active low
    input  logic                         FifoPop,
    output logic                         EndReadout,
    output logic                         FifoEmpty,
    output logic                         Overflow,      // Sticky
    output logic [DaqPkg::RegWidth-1:0]  FifoData
);
    import DaqPkg::*;

    localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
    localparam int CntW = $clog2(FifoDepth + 1);

    logic                        TxSync1, TxSync2, DoutSync1, DoutSync2;
    logic                        StartDly, Armed, GotBit;
    logic [$clog2(RegWidth)-1:0] BitCnt;
    logic [RegWidth-1:0]         ShiftReg;
    logic [RegWidth-1:0]         NewWord;
    logic                        ShiftEn, WordDone, TxRise, Push, Pop;
    logic [RegWidth-1:0]         Mem [FifoDepth];
    logic [PtrW-1:0]             WrPtr, RdPtr;
    logic [CntW-1:0]             Count;

    assign ShiftEn  = Armed && !TxSync2;
    assign NewWord  = {ShiftReg[RegWidth-2:0], DoutSync2};
    assign WordDone = ShiftEn && (BitCnt == $bits(BitCnt)'(RegWidth - 1));  // Sixteenth bit
    assign TxRise   = TxSync1 && !TxSync2;
    assign Push     = WordDone && (Count < FifoDepth);
    assign Pop      = FifoPop && !FifoEmpty;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            TxSync1    <= 1'b1;
            TxSync2    <= 1'b1;
            DoutSync1  <= 1'b0;
            DoutSync2  <= 1'b0;
            StartDly   <= 1'b0;
            Armed      <= 1'b0;
            GotBit     <= 1'b0;
            BitCnt     <= '0;
            EndReadout <= 1'b0;
            Overflow   <= 1'b0;
            WrPtr      <= '0;
            RdPtr      <= '0;
            Count      <= '0;
        end else begin
            TxSync1    <= TransmitOnB;
            TxSync2    <= TxSync1;
            DoutSync1  <= Dout;
            DoutSync2  <= DoutSync1;
            StartDly   <= StartReadout;
            EndReadout <= Armed && GotBit && TxRise;    // One cycle at end of transmission
            if (StartReadout && !StartDly) begin         // Arm on request edge
                Armed  <= 1'b1;
                GotBit <= 1'b0;
                BitCnt <= '0;
            end else if (Armed && GotBit && TxRise) begin
                Armed <= 1'b0;
            end else if (ShiftEn) begin
                GotBit <= 1'b1;
                BitCnt <= BitCnt + 1'b1;                // Wraps after each word
            end
            if (WordDone && !Push) Overflow <= 1'b1;   // Full, new word dropped
            if (Push) WrPtr <= (WrPtr == PtrW'(FifoDepth - 1)) ? '0 : WrPtr + 1'b1;
            if (Pop) RdPtr <= (RdPtr == PtrW'(FifoDepth - 1)) ? '0 : RdPtr + 1'b1;
            Count <= Count + CntW'(Push) - CntW'(Pop);
        end
    end

    // Data path
    always_ff @(posedge Clk) begin
        if (ShiftEn) ShiftReg <= NewWord;
        if (Push) Mem[WrPtr] <= NewWord;
    end

    assign FifoData  = Mem[RdPtr];      // Show-ahead
    assign FifoEmpty = (Count == '0);

    assert property (@(posedge Clk) disable iff (!reset_n) Count <= FifoDepth);

endmodule

`default_nettype wire

//--- design/SlaveDaq.sv
`timescale 1ns/1ps
`default_nettype none

module SlaveDaq (
    input  logic                         Clk,
    input  logic                         reset_n,
    input  logic                         ModuleStart,       // Held level from register block
    input  logic                         AcqStart,          // External trigger
    input  logic                         ChipSatB,          // Chain full, active low
    input  logic                         EndReadout,        // Synchronous level
    input  logic [DaqPkg::RegWidth-1:0]  AcquisitionTime,
    input  logic [DaqPkg::RegWidth-1:0]  EndHoldTime,
    output logic                         ResetB,            // ASIC digital reset
    output logic                         StartAcq,
    output logic                         StartReadout,
    output logic                         PwrOnA,
    output logic                         PwrOnD,
    output logic                         PwrOnDac,
    output logic                         OnceEnd,
    output logic                         AllDone,
    output DaqPkg::DaqStateT             State
);
    import DaqPkg::*;

    logic                ChipSatSync1, ChipSatSync2;
    logic                AcqSync1, AcqSync2;
    logic                ChipFull, ReadStart, AcqRise;
    logic                ResetStartAcq_n;   // Internal clear of StartAcq
    logic                AcqEnable;
    logic [RegWidth-1:0] DelayCount;        // Shared by every timed state

    //////////////////////////////////////////////////////////////////////
    // Input synchronizers
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ChipSatSync1 <= 1'b1;   // Idle level is not full
            ChipSatSync2 <= 1'b1;
            AcqSync1     <= 1'b0;
            AcqSync2     <= 1'b0;
        end else begin
            ChipSatSync1 <= ChipSatB;
            ChipSatSync2 <= ChipSatSync1;
            AcqSync1     <= AcqStart;
            AcqSync2     <= AcqSync1;
        end
    end

    assign ChipFull  = !ChipSatSync1 && ChipSatSync2;  // Falling edge, some chip is full
    assign ReadStart = ChipSatSync1 && !ChipSatSync2;  // Rising edge, chain ready for readout
    assign AcqRise   = AcqSync1 && !AcqSync2;

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State           <= Idle;
            ResetB          <= 1'b1;
            ResetStartAcq_n <= 1'b1;
            AcqEnable       <= 1'b0;
            StartReadout    <= 1'b0;
            OnceEnd         <= 1'b0;
            DelayCount      <= '0;
        end else begin
            case (State)
                Idle: if (ModuleStart) begin
                    ResetB          <= 1'b0;    // Hold digital part while powering
                    ResetStartAcq_n <= 1'b0;
                    State           <= ChipReset;
                end
                ChipReset: State <= PowerOn;
                PowerOn: if (DelayCount < TimeMinPowerReset) begin
                    DelayCount <= DelayCount + 1'b1;
                end else begin
                    DelayCount      <= '0;
                    ResetB          <= 1'b1;
                    ResetStartAcq_n <= 1'b1;
                    State           <= Release;
                end
                Release: if (DelayCount < TimeMinResetStart) begin
                    DelayCount <= DelayCount + 1'b1;
                end else begin
                    DelayCount <= '0;
                    AcqEnable  <= 1'b1;         // Trigger may now set StartAcq
                    State      <= WaitStart;
                end
                WaitStart: if (!ModuleStart) begin
                    AcqEnable       <= 1'b0;
                    ResetStartAcq_n <= 1'b0;    // Drop a trigger that raced the stop
                    State           <= AllDoneSt;
                end else if (AcqRise) begin
                    AcqEnable <= 1'b0;          // No retrigger inside the window
                    State     <= Acquire;
                end
                Acquire: if (DelayCount >= AcquisitionTime || ChipFull) begin
                    DelayCount      <= '0;
                    ResetStartAcq_n <= 1'b0;    // Close the acquisition
                    State           <= WaitRead;
                end else begin
                    DelayCount <= DelayCount + 1'b1;
                end
                WaitRead: if (ReadStart) begin
                    StartReadout <= 1'b1;
                    State        <= StartRead;
                end
                StartRead: if (DelayCount < TimeMinSro) begin
                    DelayCount <= DelayCount + 1'b1;
                end else begin
                    DelayCount   <= '0;
                    StartReadout <= 1'b0;
                    State        <= WaitReadDone;
                end
                WaitReadDone: if (EndReadout) begin
                    OnceEnd <= 1'b1;
                    State   <= OnceEndSt;
                end
                OnceEndSt: if (DelayCount <= EndHoldTime) begin
                    DelayCount <= DelayCount + 1'b1;
                end else begin
                    DelayCount      <= '0;
                    OnceEnd         <= 1'b0;
                    ResetStartAcq_n <= 1'b1;    // Re-arm for the next trigger
                    AcqEnable       <= 1'b1;
                    State           <= WaitStart;
                end
                AllDoneSt: begin
                    ResetStartAcq_n <= 1'b1;
                    State           <= Idle;
                end
                default: State <= Idle;
            endcase
        end
    end

    // StartAcq set straight by the trigger edge, cleared by the sequencer
    always_ff @(posedge AcqStart or negedge ResetStartAcq_n) begin
        if (!ResetStartAcq_n) begin
            StartAcq <= 1'b0;
        end else begin
            StartAcq <= AcqEnable;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Power pulsing decode
    always_comb begin
        PwrOnA   = State inside {[ChipReset:OnceEndSt]};
        PwrOnDac = PwrOnA;                              // Analog and DAC together
        PwrOnD   = State inside {[PowerOn:OnceEndSt]};  // Digital one state later
    end

    assign AllDone = (State == AllDoneSt);

    // Acquisition and readout phases are exclusive on the chain
    assert property (@(posedge Clk) disable iff (!reset_n) !(StartReadout && StartAcq));

    // Asynchronous flop only open while waiting or acquiring
    assert property (@(posedge Clk) disable iff (!reset_n)
        StartAcq |-> State inside {WaitStart, Acquire});

    assert property (@(posedge Clk) disable iff (!reset_n)
        !$isunknown(State) && State <= AllDoneSt);

endmodule

`default_nettype wire

//--- test/AsicModel.sv
`timescale 1ns/1ps
`default_nettype none

module AsicModel #(
    parameter int NumWords = 4          // Words sent per readout
) (
    input  logic Clk,
    input  logic StartAcq,
    input  logic StartReadout,
    output logic ChipSatB,              // Chain full, active low
    output logic Dout,
    output logic TransmitOnB            // Data valid, active low
);
    import DaqPkg::*;

    logic                AcqSeen;       // StartAcq level at the previous look
    logic                ReadSeen;      // StartReadout level at the previous look
    logic [RegWidth-1:0] Word;

    //////////////////////////////////////////////////////////////////////
    // Chain behavior, every change 1 ns after the rising edge
    initial begin
        ChipSatB    = 1'b1;
        Dout        = 1'b0;
        TransmitOnB = 1'b1;
        AcqSeen     = 1'b0;
        ReadSeen    = 1'b0;
        Word        = '0;
        forever begin
            @(posedge Clk);
            #1;
            // End of acquisition, chain reports full for 3 cycles
            if (AcqSeen && StartAcq === 1'b0) begin
                ChipSatB = 1'b0;
                repeat (3) @(posedge Clk);
                #1 ChipSatB = 1'b1;         // Rising edge starts the readout request
            end
            if (!ReadSeen && StartReadout === 1'b1) begin
                repeat (5) @(posedge Clk);  // Readout clock wake up
                #1;
                for (int k = 0; k < NumWords; k++) begin
                    Word = RegWidth'(16'hA500 + k);
                    for (int b = RegWidth - 1; b >= 0; b--) begin
                        TransmitOnB = 1'b0;
                        Dout        = Word[b];      // MSB first
                        @(posedge Clk);
                        #1;
                    end
                end
                TransmitOnB = 1'b1;         // End of transmission
                Dout        = 1'b0;
            end
            AcqSeen  = (StartAcq === 1'b1);
            ReadSeen = (StartReadout === 1'b1);
        end
    end

endmodule

`default_nettype wire

//--- test/DaqTb.sv
`timescale 1ns/1ps
`default_nettype none

module DaqTb;
    import DaqPkg::*;

    localparam int NumWords   = 4;
    localparam int NumAcq     = 3;
    localparam int CycleLimit = 20000;  // Three acquisitions under 600 cycles each, wide margin

    logic                Clk, reset_n;
    logic                WbCyc, WbStb, WbWe, WbAck;
    logic [2:0]          WbAdr;
    logic [RegWidth-1:0] WbDatI, WbDatO;
    logic                AcqStart, ChipSatB, Dout, TransmitOnB;
    logic                ResetB, StartAcq, StartReadout, PwrOnA, PwrOnD, PwrOnDac;
    int                  CycleCount    = 0;
    int                  ErrorCount    = 0;
    int                  ResetLowCount = 0;
    int                  ReleaseCount  = 0;
    int                  StartAcqWidth = 0;
    int                  StartReadWidth = 0;
    int                  OnceEndWidth  = 0;
    int                  AcqTime       = 8;
    int                  HoldTime      = 0;

    DaqTop UUT (
        .Clk(Clk), .reset_n(reset_n),
        .WbCyc(WbCyc), .WbStb(WbStb), .WbWe(WbWe), .WbAdr(WbAdr),
        .WbDatI(WbDatI), .WbDatO(WbDatO), .WbAck(WbAck),
        .AcqStart(AcqStart), .ChipSatB(ChipSatB), .Dout(Dout), .TransmitOnB(TransmitOnB),
        .ResetB(ResetB), .StartAcq(StartAcq), .StartReadout(StartReadout),
        .PwrOnA(PwrOnA), .PwrOnD(PwrOnD), .PwrOnDac(PwrOnDac)
    );

    AsicModel #(.NumWords(NumWords)) asic (
        .Clk(Clk), .StartAcq(StartAcq), .StartReadout(StartReadout),
        .ChipSatB(ChipSatB), .Dout(Dout), .TransmitOnB(TransmitOnB)
    );

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;          // 8 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Error handling
    task automatic abortRun();
        $display("Something failed");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic reportMismatch(input string Name, input int Expected, input int Actual);
        ErrorCount++;
        $display("Fail at %0t: %s expected 0x%0h, got 0x%0h", $time, Name, Expected, Actual);
        abortRun();
    endtask

    always @(posedge Clk) begin
        CycleCount++;
        if (CycleCount >= CycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", CycleLimit);
            abortRun();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Wishbone master, called and returning 1 ns after a rising edge
    task automatic wbAccess(input logic We, input RegAddrT Addr,
                            input logic [RegWidth-1:0] Data, output logic [RegWidth-1:0] Rd);
        WbCyc  = 1'b1;
        WbStb  = 1'b1;
        WbWe   = We;
        WbAdr  = Addr;
        WbDatI = Data;
        @(posedge Clk);
        #1;
        assert (WbAck === 1'b1) else reportMismatch("WbAck", 1, WbAck);    // One cycle latency
        Rd    = WbDatO;
        WbCyc = 1'b0;
        WbStb = 1'b0;
        WbWe  = 1'b0;
        @(posedge Clk);                 // Idle cycle while the ack drops
        #1;
    endtask

    task automatic wbWrite(input RegAddrT Addr, input logic [RegWidth-1:0] Data);
        logic [RegWidth-1:0] Unused;
        wbAccess(1'b1, Addr, Data, Unused);
    endtask

    task automatic wbRead(input RegAddrT Addr, output logic [RegWidth-1:0] Data);
        wbAccess(1'b0, Addr, '0, Data);
    endtask

    task automatic checkRead(input RegAddrT Addr, input logic [RegWidth-1:0] Expected,
                             input string Name);
        logic [RegWidth-1:0] Data;
        wbRead(Addr, Data);
        assert (Data === Expected) else reportMismatch(Name, Expected, Data);
    endtask

    // Poll the status word until the sequencer reaches Target
    task automatic waitForState(input DaqStateT Target);
        logic [RegWidth-1:0] Status;
        do begin
            wbRead(AddrStatus, Status);
        end while (Status[3:0] != Target);
    endtask

    task automatic checkIdleOutputs();
        assert (ResetB === 1'b1) else reportMismatch("ResetB", 1, ResetB);
        assert (StartAcq === 1'b0) else reportMismatch("StartAcq", 0, StartAcq);
        assert (StartReadout === 1'b0) else reportMismatch("StartReadout", 0, StartReadout);
        assert (PwrOnA === 1'b0) else reportMismatch("PwrOnA", 0, PwrOnA);
        assert (PwrOnD === 1'b0) else reportMismatch("PwrOnD", 0, PwrOnD);
        assert (PwrOnDac === 1'b0) else reportMismatch("PwrOnDac", 0, PwrOnDac);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Protocol and power sequence checks
    assert property (@(posedge Clk) disable iff (!reset_n) WbAck |-> $past(WbCyc && WbStb))
        else reportMismatch("WbAck without request", 0, 1);
    assert property (@(posedge Clk) disable iff (!reset_n)
        $rose(PwrOnD) |-> $past(PwrOnA) && $past(PwrOnDac))
        else reportMismatch("PwrOnA and PwrOnDac before PwrOnD", 1, 0);
    assert property (@(posedge Clk) disable iff (!reset_n) !ResetB |-> PwrOnA)
        else reportMismatch("PwrOnA while ResetB low", 1, 0);

    // Pulse widths, counted on the falling edge where levels are settled
    always @(negedge Clk) begin
        if (reset_n) begin
            if (ResetB === 1'b0) begin
                ResetLowCount++;
            end else if (ResetLowCount != 0) begin
                assert (ResetLowCount == TimeMinPowerReset + 2)
                    else reportMismatch("ResetB low cycles", TimeMinPowerReset + 2, ResetLowCount);
                ResetLowCount = 0;
            end
            if (UUT.State == Release) begin
                ReleaseCount++;                 // Reset released, waiting for WaitStart
            end else if (ReleaseCount != 0) begin
                assert (ReleaseCount == TimeMinResetStart + 1)
                    else reportMismatch("Release cycles", TimeMinResetStart + 1, ReleaseCount);
                ReleaseCount = 0;
            end
            if (StartAcq === 1'b1) begin
                StartAcqWidth++;
            end else if (StartAcqWidth != 0) begin
                assert (StartAcqWidth <= AcqTime + 3)
                    else reportMismatch("StartAcq width", AcqTime + 3, StartAcqWidth);
                StartAcqWidth = 0;
            end
            if (StartReadout === 1'b1) begin
                StartReadWidth++;
            end else if (StartReadWidth != 0) begin
                assert (StartReadWidth == TimeMinSro + 1)
                    else reportMismatch("StartReadout width", TimeMinSro + 1, StartReadWidth);
                StartReadWidth = 0;
            end
            if (UUT.OnceEnd === 1'b1) begin
                OnceEndWidth++;
            end else if (OnceEndWidth != 0) begin
                assert (OnceEndWidth == HoldTime + 2)
                    else reportMismatch("OnceEnd width", HoldTime + 2, OnceEndWidth);
                OnceEndWidth = 0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        int Gap;
        void'($urandom(23618));
        reset_n  = 1'b0;
        WbCyc    = 1'b0;
        WbStb    = 1'b0;
        WbWe     = 1'b0;
        WbAdr    = '0;
        WbDatI   = '0;
        AcqStart = 1'b0;
        repeat (5) @(posedge Clk);
        #1 AcqStart = 1'b1;             // Trigger edge in reset loads StartAcq low
        repeat (5) @(posedge Clk);
        #1;
        AcqStart = 1'b0;
        reset_n  = 1'b1;
        checkIdleOutputs();
        checkRead(AddrAcqTime, 16'd8, "AcquisitionTime reset value");
        checkRead(AddrStatus, 16'h0010, "Status after reset");      // Idle, FIFO empty

        for (int n = 1; n <= NumAcq; n++) begin
            AcqTime  = $urandom_range(40, 8);
            HoldTime = $urandom_range(10, 2);
            wbWrite(AddrAcqTime, RegWidth'(AcqTime));
            wbWrite(AddrHoldTime, RegWidth'(HoldTime));
            checkRead(AddrAcqTime, RegWidth'(AcqTime), "AcquisitionTime");
            checkRead(AddrHoldTime, RegWidth'(HoldTime), "EndHoldTime");
            if (n == 1) begin
                wbWrite(AddrCtrl, 16'd1);
                checkRead(AddrCtrl, 16'd1, "ModuleStart");
            end
            waitForState(WaitStart);
            Gap = $urandom_range(20, 1);
            repeat (Gap) @(posedge Clk);
            #1 AcqStart = 1'b1;
            @(posedge Clk);
            #1;
            assert (StartAcq === 1'b1) else reportMismatch("StartAcq", 1, StartAcq);
            repeat (3) @(posedge Clk);
            #1 AcqStart = 1'b0;
            waitForState(WaitStart);    // Readout done and OnceEnd over
            for (int k = 0; k < NumWords; k++) begin
                checkRead(AddrData, RegWidth'(16'hA500 + k), "FifoData");
            end
            checkRead(AddrStatus, 16'h0014, "Status after readout");    // Empty, no overflow
            checkRead(AddrData, 16'h0000, "FifoData when empty");
            checkRead(AddrCount, RegWidth'(n), "AcqCount");
        end

        // Stop the run from WaitStart
        wbWrite(AddrCtrl, 16'd0);
        waitForState(Idle);
        checkRead(AddrStatus, 16'h0030, "Status after stop");     // AllDone sticky, empty
        checkIdleOutputs();

        if (ErrorCount == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abortRun();
        end
    end

endmodule

`default_nettype wire
